// ==== verilog.f ====
+incdir+source
source/acc_isa_pkg.sv
source/acc_ctrl_pkg.sv
source/acc_alu.sv
source/acc_memory.sv
source/acc_datapath.sv
source/acc_control.sv
source/acc_computer.sv
testbench/acc_computer_properties.sv
testbench/acc_computer_tb.sv

// ==== Makefile ====
# Verilator build and run for the accumulator computer

VERILATOR  ?= verilator
TOP        ?= acc_computer_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/acc_computer_tb.sv ====
`timescale 1ns/1ps

`include "acc_cpu_defs.svh"

module acc_computer_tb import acc_isa_pkg::*; ();

    localparam int RESET_CYCLES = 8;    // Also the number of load slots
    localparam int HALT_TIMEOUT = 200;  // Longest program is well under 40 cycles
    localparam int HOLD_CYCLES  = 20;
    localparam int RANDOM_ROWS  = 24;

    typedef enum logic [2:0] {PK_ALU, PK_STORE, PK_JUMP, PK_JUMPZ, PK_UNDEF} prog_kind_e;

    typedef struct packed {
        alu_func_e                  func;
        logic [`ACC_WORD_WIDTH-1:0] a;     // Loaded first
        logic [`ACC_WORD_WIDTH-1:0] b;     // Second operand or alternative load
        prog_kind_e                 kind;
    } test_row_t;

    typedef struct packed {
        logic [`ACC_ADDR_WIDTH-1:0] addr;
        logic [`ACC_WORD_WIDTH-1:0] data;
    } load_word_t;

    logic                       clock;
    logic                       rst_n;
    logic                       load_enable;
    logic [`ACC_ADDR_WIDTH-1:0] load_address;
    logic [`ACC_WORD_WIDTH-1:0] load_data;
    logic                       halted;
    logic [`ACC_WORD_WIDTH-1:0] accumulator;
    logic [`ACC_ADDR_WIDTH-1:0] pc;

    test_row_t                  table_q[$];
    load_word_t                 image [0:RESET_CYCLES-1];  // Words written during reset
    logic [`ACC_WORD_WIDTH-1:0] exp_acc;
    logic [`ACC_ADDR_WIDTH-1:0] exp_pc;
    integer                     seed;

    acc_computer i_acc_computer (
        .clock        (clock),
        .rst_n        (rst_n),
        .load_enable  (load_enable),
        .load_address (load_address),
        .load_data    (load_data),
        .halted       (halted),
        .accumulator  (accumulator),
        .pc           (pc)
    );

    always #20 clock = ~clock;  // 40 ns period

    // Opcode, function, address, MSB first
    function automatic logic [15:0] encode(logic [3:0] opcode, logic [3:0] func,
                                           logic [7:0] addr);
        return {opcode, func, addr};
    endfunction

    // Expected accumulator for ACC op B
    function automatic logic [15:0] alu_model(alu_func_e func, logic [15:0] a, logic [15:0] b);
        logic [31:0] wide;
        wide = {16'd0, a} * {16'd0, b};
        case (func)
            FN_ADD:  return a + b;
            FN_SUB:  return a + ~b + 16'd1;  // Two's complement
            FN_MUL:  return wide[15:0];
            FN_DIV:  return (b == 16'd0) ? 16'hffff : a / b;
            FN_SHL:  return a << 1;
            FN_SHR:  return a >> 1;
            FN_ROL:  return (a << 1) | (a >> 15);
            FN_ROR:  return (a >> 1) | (a << 15);
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_XOR:  return a ^ b;
            FN_NOR:  return ~a & ~b;
            FN_NAND: return ~a | ~b;
            FN_XNOR: return (a & b) | (~a & ~b);
            FN_GT:   return (a > b) ? 16'd1 : 16'd0;
            FN_EQ:   return (a == b) ? 16'd1 : 16'd0;
            default: return 16'd0;
        endcase
    endfunction

    task automatic check(string what, logic [15:0] actual, logic [15:0] expected);
        if (actual !== expected) begin
            $display("error: %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Memory image and expected results for one row
    task automatic prepare(input test_row_t row);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            image[i] = '{8'(i), encode(OP_HALT, FN_ADD, 8'h00)};  // Spare slots halt
        end
        image[0].data = encode(OP_LOAD, FN_ADD, 8'h80);  // Every program starts LOAD A
        image[6]      = '{8'h80, row.a};
        image[7]      = '{8'h81, row.b};
        case (row.kind)
            PK_ALU: begin
                image[1].data = encode(OP_ALU, row.func, 8'h81);
                exp_acc = alu_model(row.func, row.a, row.b);
                exp_pc  = 8'd3;
            end
            PK_STORE: begin
                image[1].data = encode(OP_STORE, FN_ADD, 8'h90);
                image[2].data = encode(OP_LOAD, FN_ADD, 8'h82);  // Clears ACC
                image[3].data = encode(OP_LOAD, FN_ADD, 8'h90);
                image[5]      = '{8'h82, 16'h0000};
                image[7]      = '{8'h90, ~row.a};  // Overwritten by the store
                exp_acc = row.a;
                exp_pc  = 8'd5;
            end
            PK_JUMP: begin
                image[1].data = encode(OP_JUMP, FN_ADD, 8'h03);
                image[2].data = encode(OP_ALU, row.func, 8'h81);  // Skipped
                exp_acc = row.a;
                exp_pc  = 8'd4;
            end
            PK_JUMPZ: begin
                image[1].data = encode(OP_JUMPZ, FN_ADD, 8'h04);
                image[2].data = encode(OP_LOAD, FN_ADD, 8'h81);
                image[4].data = encode(OP_LOAD, FN_ADD, 8'h03);  // Taken path reads HALT word
                exp_acc = (row.a == 16'd0) ? image[3].data : row.b;
                exp_pc  = (row.a == 16'd0) ? 8'd6 : 8'd4;
            end
            default: begin
                image[1].data = encode(4'hb, row.func, 8'h00);  // Undefined major opcode
                exp_acc = row.a;
                exp_pc  = 8'd2;
            end
        endcase
    endtask

    task automatic run_row(input test_row_t row);
        int cycles;
        prepare(row);
        @(negedge clock);
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            load_enable  = 1'b1;
            load_address = image[i].addr;
            load_data    = image[i].data;
            @(negedge clock);
            check("halted in reset", {15'd0, halted}, 16'd0);
        end
        load_enable = 1'b0;
        rst_n       = 1'b1;
        cycles      = 0;
        while (!halted) begin  // Low until HALT is reached
            @(negedge clock);
            cycles++;
            if (cycles > HALT_TIMEOUT) begin
                $display("*** FAILED ***");
                $fatal(1, "halted did not rise within %0d cycles", HALT_TIMEOUT);
            end
        end
        check("accumulator", accumulator, exp_acc);
        check("pc", {8'd0, pc}, {8'd0, exp_pc});
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clock);
            check("halted after halt", {15'd0, halted}, 16'd1);
            check("accumulator after halt", accumulator, exp_acc);
        end
    endtask

    initial begin
        test_row_t   row;
        logic [31:0] rnd;
        clock        = 1'b0;
        rst_n        = 1'b0;
        load_enable  = 1'b0;
        load_address = '0;
        load_data    = '0;
        seed         = 32'hd0f8;
        for (int f = 0; f < 16; f++) begin
            table_q.push_back('{alu_func_e'(4'(f)), 16'h1234, 16'h00f3, PK_ALU});
            table_q.push_back('{alu_func_e'(4'(f)), 16'h8001, 16'h8001, PK_ALU});  // Equal
        end
        table_q.push_back('{FN_DIV, 16'h7fff, 16'h0000, PK_ALU});    // Divide by zero
        table_q.push_back('{FN_SUB, 16'h0000, 16'h0001, PK_ALU});    // Wraps to all ones
        table_q.push_back('{FN_MUL, 16'hff00, 16'h0101, PK_ALU});    // High half dropped
        table_q.push_back('{FN_ADD, 16'h5a5a, 16'h0000, PK_STORE});
        table_q.push_back('{FN_XOR, 16'h0f0f, 16'hffff, PK_JUMP});
        table_q.push_back('{FN_ADD, 16'h0000, 16'h1357, PK_JUMPZ});  // Taken
        table_q.push_back('{FN_ADD, 16'h0042, 16'h1357, PK_JUMPZ});  // Falls through
        table_q.push_back('{FN_ADD, 16'h3c3c, 16'h0000, PK_UNDEF});
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            rnd      = $random(seed);
            row.a    = rnd[15:0];
            row.func = alu_func_e'(rnd[19:16]);
            rnd      = $random(seed);
            row.b    = rnd[15:0];
            row.kind = PK_ALU;
            table_q.push_back(row);
        end
        foreach (table_q[i]) begin
            run_row(table_q[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== testbench/acc_computer_properties.sv ====
`timescale 1ns/1ps

module acc_computer_properties import acc_ctrl_pkg::*; (
    input logic        clock,
    input logic        rst_n,
    input ctrl_state_e state,      // Sequencer state
    input logic        mem_write,
    input logic        halted
);

    // Store write only in the operand phase
    store_phase: assert property (@(posedge clock) disable iff (!rst_n)
        mem_write |-> state == ST_OPERAND_WAIT)
        else $error("mem_write high outside ST_OPERAND_WAIT");

    // Only reset clears halted
    halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted dropped without reset");

    fetch_step: assert property (@(posedge clock) disable iff (!rst_n)
        state == ST_FETCH |=> state == ST_FETCH_WAIT)
        else $error("ST_FETCH left for a state other than ST_FETCH_WAIT");

endmodule

bind acc_control acc_computer_properties i_acc_computer_properties (
    .clock     (clock),
    .rst_n     (rst_n),
    .state     (state),
    .mem_write (mem_write),
    .halted    (halted)
);

// ==== source/acc_computer.sv ====
`timescale 1ns/1ps

`include "acc_cpu_defs.svh"

module acc_computer import acc_isa_pkg::*, acc_ctrl_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       load_enable,   // Testbench program load
    input  logic [`ACC_ADDR_WIDTH-1:0] load_address,
    input  logic [`ACC_WORD_WIDTH-1:0] load_data,
    output logic                       halted,
    output logic [`ACC_WORD_WIDTH-1:0] accumulator,
    output logic [`ACC_ADDR_WIDTH-1:0] pc
);

    datapath_ctrl_t             ctrl;
    instruction_t               instruction;
    logic                       mem_write;
    logic                       acc_zero;
    logic [`ACC_ADDR_WIDTH-1:0] address;
    logic [`ACC_WORD_WIDTH-1:0] read_data;
    logic [`ACC_WORD_WIDTH-1:0] memory_buffer;
    logic [`ACC_WORD_WIDTH-1:0] alu_result;

    acc_control i_acc_control (
        .clock       (clock),
        .rst_n       (rst_n),
        .instruction (instruction),
        .acc_zero    (acc_zero),
        .ctrl        (ctrl),
        .mem_write   (mem_write),
        .halted      (halted)
    );

    acc_datapath i_acc_datapath (
        .clock         (clock),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .read_data     (read_data),
        .alu_result    (alu_result),
        .address       (address),
        .accumulator   (accumulator),
        .memory_buffer (memory_buffer),
        .instruction   (instruction),
        .acc_zero      (acc_zero),
        .pc            (pc)
    );

    acc_alu i_acc_alu (
        .func      (instruction.func),
        .operand_a (accumulator),
        .operand_b (memory_buffer),
        .result    (alu_result)
    );

    acc_memory i_acc_memory (
        .clock        (clock),
        .address      (address),
        .write_data   (accumulator),  // Only STORE writes
        .mem_write    (mem_write),
        .load_enable  (load_enable),
        .load_address (load_address),
        .load_data    (load_data),
        .read_data    (read_data)
    );

endmodule

// ==== source/acc_control.sv ====
`timescale 1ns/1ps

module acc_control import acc_isa_pkg::*, acc_ctrl_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  instruction_t   instruction,  // Valid from ST_OPERAND on
    input  logic           acc_zero,
    output datapath_ctrl_t ctrl,
    output logic           mem_write,
    output logic           halted
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        is_store;

    assign is_store = (instruction.opcode == OP_STORE);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    // Moore strobes per state, opcode steers the operand phases
    always_comb begin
        ctrl       = '0;
        next_state = state;
        case (state)
            ST_FETCH: begin
                ctrl.mar_from_pc = 1'b1;
                next_state       = ST_FETCH_WAIT;
            end
            ST_FETCH_WAIT: begin
                next_state = ST_DECODE;  // Memory latency
            end
            ST_DECODE: begin
                ctrl.ir_load = 1'b1;
                ctrl.pc_inc  = 1'b1;
                next_state   = ST_OPERAND;
            end
            ST_OPERAND: begin
                case (instruction.opcode)
                    OP_LOAD, OP_STORE, OP_ALU: begin
                        ctrl.mar_from_ir = 1'b1;
                        next_state       = ST_OPERAND_WAIT;
                    end
                    OP_JUMP: begin
                        ctrl.pc_load = 1'b1;
                        next_state   = ST_FETCH;
                    end
                    OP_JUMPZ: begin
                        ctrl.pc_load = acc_zero;  // Falls through otherwise
                        next_state   = ST_FETCH;
                    end
                    default: next_state = ST_HALTED;  // HALT and undefined opcodes
                endcase
            end
            ST_OPERAND_WAIT: begin
                ctrl.mem_write = is_store;  // MAR already points at operand
                next_state     = is_store ? ST_FETCH : ST_EXECUTE;
            end
            ST_EXECUTE: begin
                ctrl.acc_from_mem = (instruction.opcode == OP_LOAD);
                ctrl.acc_from_alu = (instruction.opcode == OP_ALU);
                next_state        = ST_FETCH;
            end
            ST_HALTED: next_state = ST_HALTED;  // Only reset leaves
            default:   next_state = ST_HALTED;  // Unused encoding
        endcase
    end

    assign mem_write = ctrl.mem_write;
    assign halted    = (state == ST_HALTED);

endmodule

// ==== source/acc_datapath.sv ====
`timescale 1ns/1ps

`include "acc_cpu_defs.svh"

module acc_datapath import acc_isa_pkg::*, acc_ctrl_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  datapath_ctrl_t             ctrl,
    input  logic [`ACC_WORD_WIDTH-1:0] read_data,      // Registered memory output
    input  logic [`ACC_WORD_WIDTH-1:0] alu_result,
    output logic [`ACC_ADDR_WIDTH-1:0] address,        // MAR to memory
    output logic [`ACC_WORD_WIDTH-1:0] accumulator,
    output logic [`ACC_WORD_WIDTH-1:0] memory_buffer,  // MBR to ALU operand B
    output instruction_t               instruction,    // IR
    output logic                       acc_zero,
    output logic [`ACC_ADDR_WIDTH-1:0] pc
);

    logic [`ACC_ADDR_WIDTH-1:0] pc_q;
    logic [`ACC_ADDR_WIDTH-1:0] mar_q;
    logic [`ACC_WORD_WIDTH-1:0] acc_q;
    instruction_t               ir_q;

    // Program counter, jump beats increment
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (ctrl.pc_load) begin
            pc_q <= ir_q.address;
        end else if (ctrl.pc_inc) begin
            pc_q <= pc_q + `ACC_ADDR_WIDTH'(1);  // Wraps at 256
        end
    end

    // Accumulator
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (ctrl.acc_from_alu) begin
            acc_q <= alu_result;
        end else if (ctrl.acc_from_mem) begin
            acc_q <= read_data;
        end
    end

    // MAR and IR carry payload only
    always_ff @(posedge clock) begin
        if (ctrl.mar_from_ir) begin
            mar_q <= ir_q.address;    // Operand fetch
        end else if (ctrl.mar_from_pc) begin
            mar_q <= pc_q;            // Instruction fetch
        end
        if (ctrl.ir_load) begin
            ir_q <= instruction_t'(read_data);
        end
    end

    assign memory_buffer = read_data;  // Memory output register acts as MBR
    assign address       = mar_q;
    assign accumulator   = acc_q;
    assign instruction   = ir_q;
    assign pc            = pc_q;
    assign acc_zero      = (acc_q == '0);

endmodule

// ==== source/acc_memory.sv ====
`timescale 1ns/1ps

`include "acc_cpu_defs.svh"

module acc_memory (
    input  logic                       clock,
    input  logic [`ACC_ADDR_WIDTH-1:0] address,       // CPU side, from MAR
    input  logic [`ACC_WORD_WIDTH-1:0] write_data,    // Accumulator
    input  logic                       mem_write,
    input  logic                       load_enable,   // Program load, used in reset
    input  logic [`ACC_ADDR_WIDTH-1:0] load_address,
    input  logic [`ACC_WORD_WIDTH-1:0] load_data,
    output logic [`ACC_WORD_WIDTH-1:0] read_data      // One cycle after address
);

    logic [`ACC_WORD_WIDTH-1:0] mem [0:`ACC_MEM_DEPTH-1];  // Shared program and data

    // Write port, loader wins over CPU
    always_ff @(posedge clock) begin
        if (load_enable) begin
            mem[load_address] <= load_data;
        end else if (mem_write) begin
            mem[address] <= write_data;
        end
    end

    // Registered read every cycle, old data on collision
    always_ff @(posedge clock) begin
        read_data <= mem[address];
    end

endmodule

// ==== source/acc_alu.sv ====
`timescale 1ns/1ps

`include "acc_cpu_defs.svh"

module acc_alu import acc_isa_pkg::*; (
    input  alu_func_e                 func,
    input  logic [`ACC_WORD_WIDTH-1:0] operand_a,  // Accumulator
    input  logic [`ACC_WORD_WIDTH-1:0] operand_b,  // Memory word
    output logic [`ACC_WORD_WIDTH-1:0] result
);

    localparam int W = `ACC_WORD_WIDTH;

    logic [W-1:0] product;  // Low half of the product only
    logic         div_zero;

    assign product  = operand_a * operand_b;
    assign div_zero = (operand_b == '0);

    always_comb begin
        case (func)
            FN_ADD:  result = operand_a + operand_b;
            FN_SUB:  result = operand_a - operand_b;
            FN_MUL:  result = product;
            FN_DIV:  result = div_zero ? '1 : operand_a / operand_b;  // Saturate on /0
            FN_SHL:  result = {operand_a[W-2:0], 1'b0};
            FN_SHR:  result = {1'b0, operand_a[W-1:1]};
            FN_ROL:  result = {operand_a[W-2:0], operand_a[W-1]};
            FN_ROR:  result = {operand_a[0], operand_a[W-1:1]};
            FN_AND:  result = operand_a & operand_b;
            FN_OR:   result = operand_a | operand_b;
            FN_XOR:  result = operand_a ^ operand_b;
            FN_NOR:  result = ~(operand_a | operand_b);
            FN_NAND: result = ~(operand_a & operand_b);
            FN_XNOR: result = ~(operand_a ^ operand_b);
            FN_GT:   result = {{(W-1){1'b0}}, (operand_a > operand_b)};  // Unsigned
            FN_EQ:   result = {{(W-1){1'b0}}, (operand_a == operand_b)};
            default: result = '0;
        endcase
    end

endmodule

// ==== source/acc_ctrl_pkg.sv ====
package acc_ctrl_pkg;

    // Sequencer states, one cycle each except halted
    typedef enum logic [2:0] {
        ST_FETCH        = 3'd0,  // MAR <= PC
        ST_FETCH_WAIT   = 3'd1,  // Instruction read in flight
        ST_DECODE       = 3'd2,  // IR <= mem, PC++
        ST_OPERAND      = 3'd3,  // MAR <= IR address, jumps resolve
        ST_OPERAND_WAIT = 3'd4,  // Operand read or store write
        ST_EXECUTE      = 3'd5,  // ACC update
        ST_HALTED       = 3'd6   // Sticky until reset
    } ctrl_state_e;

    // Per-cycle strobes into the datapath
    typedef struct packed {
        logic mar_from_pc;    // Instruction address
        logic mar_from_ir;    // Operand address
        logic ir_load;
        logic pc_inc;
        logic pc_load;        // Jump target from IR
        logic acc_from_mem;   // LOAD
        logic acc_from_alu;   // ALU op
        logic mem_write;      // STORE
    } datapath_ctrl_t;

endpackage

// ==== source/acc_isa_pkg.sv ====
`include "acc_cpu_defs.svh"

package acc_isa_pkg;

    // Major opcodes, values 6 to 15 are undefined and halt
    typedef enum logic [`ACC_OPCODE_WIDTH-1:0] {
        OP_LOAD  = 4'h0,    // ACC <= mem[addr]
        OP_STORE = 4'h1,    // mem[addr] <= ACC
        OP_ALU   = 4'h2,    // ACC <= ACC op mem[addr]
        OP_JUMP  = 4'h3,    // PC <= addr
        OP_JUMPZ = 4'h4,    // PC <= addr when ACC is zero
        OP_HALT  = 4'h5     // Stop until reset
    } major_opcode_e;

    // ALU functions, full 4-bit space
    typedef enum logic [`ACC_FUNC_WIDTH-1:0] {
        FN_ADD  = 4'h0,
        FN_SUB  = 4'h1,
        FN_MUL  = 4'h2,     // Low half of product
        FN_DIV  = 4'h3,     // All ones on zero divisor
        FN_SHL  = 4'h4,     // Accumulator only
        FN_SHR  = 4'h5,
        FN_ROL  = 4'h6,
        FN_ROR  = 4'h7,
        FN_AND  = 4'h8,
        FN_OR   = 4'h9,
        FN_XOR  = 4'ha,
        FN_NOR  = 4'hb,
        FN_NAND = 4'hc,
        FN_XNOR = 4'hd,
        FN_GT   = 4'he,     // Unsigned compare, 1 or 0
        FN_EQ   = 4'hf
    } alu_func_e;

    typedef struct packed {
        major_opcode_e                opcode;   // Bits 15:12
        alu_func_e                    func;     // Bits 11:8
        logic [`ACC_ADDR_WIDTH-1:0]   address;  // Bits 7:0
    } instruction_t;

endpackage

// ==== source/acc_cpu_defs.svh ====
`ifndef ACC_CPU_DEFS_SVH
`define ACC_CPU_DEFS_SVH

// Data path and instruction word
`define ACC_WORD_WIDTH 16

// Memory geometry
`define ACC_ADDR_WIDTH 8
`define ACC_MEM_DEPTH 256     // Program and data share one space

// Instruction fields, MSB first: opcode, func, address
`define ACC_OPCODE_WIDTH 4
`define ACC_FUNC_WIDTH 4

`endif
